// ==== src.f ====
+incdir+verilog
verilog/video_pkg.sv
verilog/track_pkg.sv
verilog/debounce.sv
verilog/cursor_mover.sv
verilog/sync_delay.sv
verilog/overlay_mixer.sv
verilog/readout_latch.sv
verilog/video_overlay.sv
test/video_overlay_tb.sv

// ==== test/video_overlay_tb.sv ====
//////////////////////////////
// video overlay testbench
// table driven stimulus checked against a cycle model of the stage
//////////////////////////////

`default_nettype none

`include "overlay_macros.svh"

module video_overlay_tb;

	// one table row and the number of cycles it is held
	typedef struct packed {
		logic [1:0] mode;
		video_pkg::raster_t raster;
		video_pkg::rgb666_t pixel;
		video_pkg::hsv_t hsv;
		track_pkg::pos_t com;
		logic com_rdy;
		track_pkg::pos_t light;
		track_pkg::buttons_t btn;
		logic [15:0] hold;
	} row_t;

	localparam logic [17:0] FIXED_PIXEL = 18'h2A5C3;
	localparam track_pkg::pos_t COM = '{x: 11'd300, y: 10'd200};
	// com_pos between strobes, far from every raster in the table
	localparam track_pkg::pos_t COM_IDLE = '{x: 11'd700, y: 10'd600};
	localparam track_pkg::pos_t LIGHT = '{x: 11'd500, y: 10'd400};

	logic clk;
	logic rst;
	logic [1:0] switches;
	track_pkg::buttons_t buttons;
	video_pkg::raster_t raster;
	video_pkg::rgb666_t pixel_in;
	video_pkg::hsv_t hsv_in;
	track_pkg::pos_t com_pos;
	track_pkg::pos_t light_pos;
	logic com_ready;
	video_pkg::rgb666_t pixel_out;
	logic hsync_out;
	logic vsync_out;
	logic blank_out;
	track_pkg::readout_t readout;

	row_t rows[$];
	logic [15:0] lfsr;
	int errors;
	int checks;
	int limit_cycles;

	//////////////////////////////
	// reference model state
	//////////////////////////////

	video_pkg::raster_t hist [`HSV_DELAY];
	int db_cnt [4];
	track_pkg::buttons_t db_clean;
	logic [`CURSOR_STEP_LOG2-1:0] step_cnt;
	track_pkg::pos_t m_cursor;
	track_pkg::pos_t m_com;
	video_pkg::rgb666_t exp_pixel;
	logic exp_hsync;
	logic exp_vsync;
	logic exp_blank;
	track_pkg::readout_t exp_readout;
	logic model_valid = 1'b0;

	video_overlay u_video_overlay (
		.clk(clk),
		.rst(rst),
		.switches(switches),
		.buttons(buttons),
		.raster(raster),
		.pixel_in(pixel_in),
		.hsv_in(hsv_in),
		.com_pos(com_pos),
		.light_pos(light_pos),
		.com_ready(com_ready),
		.pixel_out(pixel_out),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out),
		.blank_out(blank_out),
		.readout(readout)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// 16-bit galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per pixel bit
	task automatic random_pixel(output video_pkg::rgb666_t px);
		for (int i = 0; i < 18; i++) begin
			lfsr = lfsr_next(lfsr);
			px[i] = lfsr[0];
		end
	endtask

	function automatic video_pkg::raster_t make_raster(input int hc, input int vc,
		input logic [2:0] sync);
		video_pkg::raster_t r;
		r.hcount = 11'(hc);
		r.vcount = 10'(vc);
		{r.hsync, r.vsync, r.blank} = sync;
		return r;
	endfunction

	// expected pixel from the mode rules using the state from before the edge
	function automatic video_pkg::rgb666_t expected_pixel(input logic [1:0] mode,
		input video_pkg::raster_t r, input video_pkg::rgb666_t px, input video_pkg::hsv_t hsv,
		input track_pkg::pos_t com, input track_pkg::pos_t cur, input track_pkg::pos_t light);
		int dx;
		int dy;
		logic near;
		logic light_hit;
		logic cur_hit;
		logic hue_in;
		logic sv_in;
		dx = int'(r.hcount) - int'(com.x);
		dy = int'(r.vcount) - int'(com.y);
		near = (dx >= -`MARK_HALF && dx <= `MARK_HALF) || (dy >= -`MARK_HALF && dy <= `MARK_HALF);
		light_hit = (r.hcount == light.x) || (r.vcount == light.y);
		cur_hit = (r.hcount == cur.x) || (r.vcount == cur.y);
		hue_in = (hsv.h >= `HUE_LOW) && (hsv.h <= `HUE_HIGH);
		sv_in = (hsv.s > `SV_MIN) && (hsv.v > `SV_MIN);
		if (mode == video_pkg::MODE_TRACK && near) return `COLOR_GREEN;
		if (mode == video_pkg::MODE_CURSOR && cur_hit) return `COLOR_GREEN;
		if ((mode == video_pkg::MODE_TRACK || mode == video_pkg::MODE_CURSOR) && light_hit)
			return `COLOR_BLUE;
		if (mode == video_pkg::MODE_HSV) begin
			if (hue_in && sv_in) return `COLOR_WHITE;
			if (hue_in) return `COLOR_RED;
			if (sv_in) return `COLOR_BLUE;
			return `COLOR_BLACK;
		end
		return px;
	endfunction

	always @(posedge clk) begin
		video_pkg::raster_t rdel;
		model_valid = 1'b1;
		if (rst) begin
			for (int i = 0; i < `HSV_DELAY; i++) begin
				hist[i] = '0;
			end
			for (int i = 0; i < 4; i++) begin
				db_cnt[i] = 0;
			end
			db_clean = '0;
			step_cnt = '0;
			m_cursor = '0;
			m_com = '0;
			exp_pixel = '0;
			{exp_hsync, exp_vsync, exp_blank} = 3'b001;
			exp_readout = '0;
		end else begin
			// oldest history entry lines up with this cycle's hsv
			rdel = hist[`HSV_DELAY-1];
			exp_pixel = expected_pixel(switches, raster, pixel_in, hsv_in, m_com, m_cursor,
				light_pos);
			if (switches == video_pkg::MODE_HSV) begin
				{exp_hsync, exp_vsync, exp_blank} = {rdel.hsync, rdel.vsync, rdel.blank};
			end else begin
				{exp_hsync, exp_vsync, exp_blank} = {raster.hsync, raster.vsync, raster.blank};
			end
			if (switches[0] && rdel.hcount == m_com.x && rdel.vcount == m_com.y) begin
				exp_readout = {hsv_in.h, m_com};
			end else if (rdel.hcount == m_cursor.x && rdel.vcount == m_cursor.y) begin
				exp_readout = {hsv_in.h, m_cursor};
			end
			// state moves after the outputs were worked out
			for (int i = `HSV_DELAY - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = raster;
			if (com_ready) m_com = com_pos;
			if (step_cnt == '0) begin
				if (db_clean.right && m_cursor.x < `X_MAX) m_cursor.x++;
				else if (db_clean.left && m_cursor.x > 0) m_cursor.x--;
				if (db_clean.down && m_cursor.y < `Y_MAX) m_cursor.y++;
				else if (db_clean.up && m_cursor.y > 0) m_cursor.y--;
			end
			step_cnt = step_cnt + 1'b1;
			// output follows once a full run of differing samples is seen
			for (int i = 0; i < 4; i++) begin
				if (buttons[i] != db_clean[i]) begin
					db_cnt[i]++;
					if (db_cnt[i] == `DEBOUNCE_CYCLES) begin
						db_clean[i] = buttons[i];
						db_cnt[i] = 0;
					end
				end else begin
					db_cnt[i] = 0;
				end
			end
		end
	end

	//////////////////////////////
	// checks on the falling edge
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	always @(negedge clk) begin
		if (model_valid) begin
			check_value("pixel_out", pixel_out, exp_pixel);
			check_value("hsync_out", hsync_out, exp_hsync);
			check_value("vsync_out", vsync_out, exp_vsync);
			check_value("blank_out", blank_out, exp_blank);
			check_value("readout", readout, exp_readout);
		end
	end

	task automatic add_row(input logic [1:0] mode, input video_pkg::raster_t r,
		input video_pkg::hsv_t hsv, input logic rdy, input track_pkg::buttons_t btn,
		input int hold);
		row_t row;
		row.mode = mode;
		row.raster = r;
		row.pixel = FIXED_PIXEL;
		row.hsv = hsv;
		row.com = rdy ? COM : COM_IDLE;
		row.com_rdy = rdy;
		row.light = LIGHT;
		row.btn = btn;
		row.hold = 16'(hold);
		rows.push_back(row);
	endtask

	task automatic build_table();
		// video mode with lfsr pixels and changing syncs
		add_row(video_pkg::MODE_VIDEO, make_raster(100, 50, 3'b100), 24'h0, 1'b0, 4'b0000, 6);
		add_row(video_pkg::MODE_VIDEO, make_raster(101, 50, 3'b010), 24'h0, 1'b0, 4'b0000, 6);
		add_row(video_pkg::MODE_VIDEO, make_raster(102, 51, 3'b111), 24'h0, 1'b0, 4'b0000, 6);
		// hsv classes at and around the window edges
		add_row(video_pkg::MODE_HSV, make_raster(200, 60, 3'b000), 24'hEB8989, 1'b0, 4'b0, 3);
		add_row(video_pkg::MODE_HSV, make_raster(201, 60, 3'b100), 24'hFAFF89, 1'b0, 4'b0, 3);
		add_row(video_pkg::MODE_HSV, make_raster(202, 60, 3'b010), 24'hF088FF, 1'b0, 4'b0, 3);
		add_row(video_pkg::MODE_HSV, make_raster(203, 60, 3'b001), 24'hEA9090, 1'b0, 4'b0, 3);
		add_row(video_pkg::MODE_HSV, make_raster(204, 61, 3'b110), 24'hFB1010, 1'b0, 4'b0, 3);
		add_row(video_pkg::MODE_HSV, make_raster(205, 61, 3'b011), 24'hF0FF88, 1'b0, 4'b0, 24);
		// strobe the centre then walk across the tracking cross
		add_row(video_pkg::MODE_TRACK, make_raster(600, 700, 3'b000), 24'h0, 1'b1, 4'b0, 3);
		for (int d = -3; d <= 3; d++) begin
			add_row(video_pkg::MODE_TRACK, make_raster(300 + d, 10, 3'b000), 24'h0, 1'b0, 4'b0, 1);
		end
		add_row(video_pkg::MODE_TRACK, make_raster(500, 10, 3'b000), 24'h0, 1'b0, 4'b0, 1);
		add_row(video_pkg::MODE_TRACK, make_raster(10, 202, 3'b000), 24'h0, 1'b0, 4'b0, 1);
		// cursor goes right and down, coasts on release, then left and up back to zero
		add_row(video_pkg::MODE_CURSOR, make_raster(4, 4, 3'b000), 24'h0, 1'b0, 4'b0101, 70);
		add_row(video_pkg::MODE_CURSOR, make_raster(5, 900, 3'b000), 24'h0, 1'b0, 4'b0000, 10);
		add_row(video_pkg::MODE_CURSOR, make_raster(0, 0, 3'b000), 24'h0, 1'b0, 4'b1010, 150);
		// readout loads com, then the cursor, then ignores com and holds
		add_row(video_pkg::MODE_TRACK, make_raster(300, 200, 3'b000), 24'h5C9999, 1'b0, 4'b0, 26);
		add_row(video_pkg::MODE_CURSOR, make_raster(0, 0, 3'b000), 24'h779999, 1'b0, 4'b0, 26);
		add_row(video_pkg::MODE_CURSOR, make_raster(300, 200, 3'b000), 24'h339999, 1'b0, 4'b0, 26);
		add_row(video_pkg::MODE_VIDEO, make_raster(123, 45, 3'b000), 24'h119999, 1'b0, 4'b0, 26);
	endtask

	// drive one cycle of a row just after the rising edge
	task automatic apply_row(input row_t r, input logic first);
		video_pkg::rgb666_t px;
		@(posedge clk);
		if (r.mode == video_pkg::MODE_VIDEO) begin
			random_pixel(px);
		end else begin
			px = r.pixel;
		end
		switches <= r.mode;
		raster <= r.raster;
		pixel_in <= px;
		hsv_in <= r.hsv;
		com_pos <= r.com;
		com_ready <= r.com_rdy && first;
		light_pos <= r.light;
		buttons <= r.btn;
	endtask

	initial begin
		int total;
		errors = 0;
		checks = 0;
		limit_cycles = 0;
		lfsr = 16'd93;
		rst = 1'b1;
		switches = '0;
		buttons = '0;
		raster = '0;
		pixel_in = '0;
		hsv_in = '0;
		com_pos = '0;
		light_pos = '0;
		com_ready = 1'b0;
		build_table();
		total = 0;
		foreach (rows[i]) begin
			total += rows[i].hold;
		end
		limit_cycles = total + 50;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		foreach (rows[i]) begin
			for (int c = 0; c < rows[i].hold; c++) begin
				apply_row(rows[i], c == 0);
			end
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog armed once the table length is known
	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * 100);
		$display("timeout: the run did not end within %0d cycles", limit_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cursor_mover.sv ====
//////////////////////////////
// cursor mover
// slow stepping cursor, clamped to the screen bounds
//////////////////////////////

`default_nettype none

`include "overlay_macros.svh"

module cursor_mover (
	input wire logic clk,
	input wire logic rst,
	input wire track_pkg::buttons_t buttons,
	output track_pkg::pos_t cursor
);

	// free running prescaler, cursor moves when it wraps to zero
	logic [`CURSOR_STEP_LOG2-1:0] step_cnt;
	logic step;

	assign step = (step_cnt == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			step_cnt <= '0;
		end else begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// position update
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			cursor <= '0;
		end else if (step) begin
			// vertical, down wins when both are held
			if (buttons.down && cursor.y < `Y_MAX) begin
				cursor.y <= cursor.y + 10'd1;
			end else if (buttons.up && cursor.y > 10'd0) begin
				cursor.y <= cursor.y - 10'd1;
			end

			// horizontal, right wins over left
			if (buttons.right && cursor.x < `X_MAX) begin
				cursor.x <= cursor.x + 11'd1;
			end else if (buttons.left && cursor.x > 11'd0) begin
				cursor.x <= cursor.x - 11'd1;
			end
		end
	end

	// readout and mixer compare against hcount/vcount, never let it escape
	a_in_bounds: assert property (@(posedge clk) disable iff (rst)
		cursor.x <= `X_MAX && cursor.y <= `Y_MAX);

endmodule

`default_nettype wire

// ==== verilog/debounce.sv ====
//////////////////////////////
// button debouncer
//////////////////////////////

`default_nettype none

`include "overlay_macros.svh"

module debounce (
	input wire logic clk,
	input wire logic rst,
	input wire logic raw,
	output logic clean
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

	// cycles in a row that raw has disagreed with clean
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			clean <= 1'b0;
		end else if (raw == clean) begin
			// glitch or back to the settled level, start over
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			// this edge is the last of a full stable run
			clean <= raw;
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// output may only move after a complete run of the new level
	a_full_count: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) && $changed(clean) |-> $past(cnt) == CNT_LAST && $past(raw) == clean);

endmodule

`default_nettype wire

// ==== verilog/overlay_macros.svh ====
//////////////////////////////
// overlay constants
// thresholds, delays, cursor bounds and overlay colours
//////////////////////////////

`ifndef OVERLAY_MACROS_SVH
`define OVERLAY_MACROS_SVH

// consecutive stable cycles before a button output follows
`define DEBOUNCE_CYCLES 16

// cursor steps once every 2**CURSOR_STEP_LOG2 cycles
`define CURSOR_STEP_LOG2 3

// latency of the upstream hsv converter (dividers)
`define HSV_DELAY 22

// inclusive cursor bounds, one past the visible xga area
`define X_MAX 11'd1024
`define Y_MAX 10'd768

// hue window of the tracked colour, inclusive at both ends
`define HUE_LOW 8'hEB
`define HUE_HIGH 8'hFA

// s and v have to be strictly above this
`define SV_MIN 8'h88

// tracking cross half-width in pixels
`define MARK_HALF 2

// rgb666 colours, r in the top six bits
`define COLOR_GREEN 18'b000000_111111_000000
`define COLOR_BLUE 18'b000000_000000_111111
`define COLOR_RED 18'b111111_000000_000000
`define COLOR_WHITE 18'b111111_111111_111111
`define COLOR_BLACK 18'b000000_000000_000000

`endif

// ==== verilog/overlay_mixer.sv ====
//////////////////////////////
// overlay mixer
// draws crosses or the hsv classes over the video
//////////////////////////////

`default_nettype none

`include "overlay_macros.svh"

module overlay_mixer (
	input wire logic clk,
	input wire logic rst,
	input wire video_pkg::overlay_mode_e mode,
	input wire video_pkg::raster_t raster,
	input wire video_pkg::raster_t raster_del,
	input wire video_pkg::rgb666_t pixel_in,
	input wire video_pkg::hsv_t hsv_in,
	input wire track_pkg::pos_t com_pos,
	input wire track_pkg::pos_t light_pos,
	input wire track_pkg::pos_t cursor,
	input wire logic com_ready,
	output video_pkg::rgb666_t pixel_out,
	output logic hsync_out,
	output logic vsync_out,
	output logic blank_out,
	output track_pkg::pos_t com_latched
);

	// hold the last centre of mass, tracker only strobes once a frame
	always_ff @(posedge clk) begin
		if (rst) begin
			com_latched <= '0;
		end else if (com_ready) begin
			com_latched <= com_pos;
		end
	end

	//////////////////////////////
	// cross and class decode
	//////////////////////////////

	logic near_com;
	logic on_light;
	logic on_cursor;
	logic hue_ok;
	logic sv_ok;
	video_pkg::rgb666_t pixel_next;

	// within MARK_HALF either side, widened by a bit so +2 cannot wrap
	assign near_com =
		({1'b0, raster.hcount} + 12'(`MARK_HALF) >= {1'b0, com_latched.x} &&
		 {1'b0, com_latched.x} + 12'(`MARK_HALF) >= {1'b0, raster.hcount}) ||
		({1'b0, raster.vcount} + 11'(`MARK_HALF) >= {1'b0, com_latched.y} &&
		 {1'b0, com_latched.y} + 11'(`MARK_HALF) >= {1'b0, raster.vcount});

	assign on_light = (raster.hcount == light_pos.x) || (raster.vcount == light_pos.y);
	assign on_cursor = (raster.hcount == cursor.x) || (raster.vcount == cursor.y);

	// hue window inclusive, s and v strictly above threshold
	assign hue_ok = (hsv_in.h >= `HUE_LOW) && (hsv_in.h <= `HUE_HIGH);
	assign sv_ok = (hsv_in.s > `SV_MIN) && (hsv_in.v > `SV_MIN);

	always_comb begin
		pixel_next = pixel_in;
		case (mode)
			video_pkg::MODE_TRACK: begin
				if (near_com) pixel_next = `COLOR_GREEN;
				else if (on_light) pixel_next = `COLOR_BLUE;
			end
			video_pkg::MODE_CURSOR: begin
				// thin cross, one pixel wide
				if (on_cursor) pixel_next = `COLOR_GREEN;
				else if (on_light) pixel_next = `COLOR_BLUE;
			end
			video_pkg::MODE_HSV: begin
				if (hue_ok && sv_ok) pixel_next = `COLOR_WHITE;
				else if (hue_ok) pixel_next = `COLOR_RED;
				else if (sv_ok) pixel_next = `COLOR_BLUE;
				else pixel_next = `COLOR_BLACK;
			end
			default: pixel_next = pixel_in;
		endcase
	end

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_out <= '0;
			hsync_out <= 1'b0;
			vsync_out <= 1'b0;
			blank_out <= 1'b1;
		end else begin
			pixel_out <= pixel_next;
			// hsv pixels are 22 cycles late so the syncs have to be too
			if (mode == video_pkg::MODE_HSV) begin
				hsync_out <= raster_del.hsync;
				vsync_out <= raster_del.vsync;
				blank_out <= raster_del.blank;
			end else begin
				hsync_out <= raster.hsync;
				vsync_out <= raster.vsync;
				blank_out <= raster.blank;
			end
		end
	end

	// switches come straight from the top, must be settled once out of reset
	a_mode_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(mode));

endmodule

`default_nettype wire

// ==== verilog/readout_latch.sv ====
//////////////////////////////
// hex readout latch
// grabs hue and position when the delayed raster hits a marker
//////////////////////////////

`default_nettype none

module readout_latch (
	input wire logic clk,
	input wire logic rst,
	input wire logic track_en,
	input wire video_pkg::raster_t raster_del,
	input wire video_pkg::hsv_t hsv_in,
	input wire track_pkg::pos_t com_latched,
	input wire track_pkg::pos_t cursor,
	output track_pkg::readout_t readout
);

	logic at_com;
	logic at_cursor;

	// raster_del is aligned with hsv_in, so the hue belongs to this spot
	assign at_com = (raster_del.hcount == com_latched.x) &&
		(raster_del.vcount == com_latched.y);
	assign at_cursor = (raster_del.hcount == cursor.x) &&
		(raster_del.vcount == cursor.y);

	always_ff @(posedge clk) begin
		if (rst) begin
			readout <= '0;
		end else if (track_en && at_com) begin
			// centre of mass has priority while tracking
			readout.hue <= hsv_in.h;
			readout.pos <= com_latched;
		end else if (at_cursor) begin
			readout.hue <= hsv_in.h;
			readout.pos <= cursor;
		end
		// otherwise hold so the display stays readable
	end

endmodule

`default_nettype wire

// ==== verilog/sync_delay.sv ====
//////////////////////////////
// raster delay line
// lines the raster up with the late hsv data
//////////////////////////////

`default_nettype none

`include "overlay_macros.svh"

module sync_delay #(
	parameter int DEPTH = `HSV_DELAY
) (
	input wire logic clk,
	input wire logic rst,
	input wire video_pkg::raster_t raster,
	output video_pkg::raster_t raster_del
);

	// one full raster word per stage
	video_pkg::raster_t pipe [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			// flush so the output reads zero until real data arrives
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= raster;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	// oldest stage
	assign raster_del = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== verilog/track_pkg.sv ====
//////////////////////////////
// tracking types
// screen positions, buttons and hex readout word
//////////////////////////////

`default_nettype none

package track_pkg;

	// screen position, same widths as hcount/vcount
	typedef struct packed {
		logic [10:0] x;
		logic [9:0] y;
	} pos_t;

	// direction buttons, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	// word for the hex display
	// hue of the pixel under the marker plus where that marker is
	typedef struct packed {
		logic [7:0] hue;
		pos_t pos;
	} readout_t;

endpackage

`default_nettype wire

// ==== verilog/video_overlay.sv ====
//////////////////////////////
// video overlay stage
// buttons, cursor, hsv alignment, mixer and hex readout
//////////////////////////////

`default_nettype none

module video_overlay (
	input wire logic clk,
	input wire logic rst,
	input wire logic [1:0] switches,
	input wire track_pkg::buttons_t buttons,
	input wire video_pkg::raster_t raster,
	input wire video_pkg::rgb666_t pixel_in,
	input wire video_pkg::hsv_t hsv_in,
	input wire track_pkg::pos_t com_pos,
	input wire track_pkg::pos_t light_pos,
	input wire logic com_ready,
	output video_pkg::rgb666_t pixel_out,
	output logic hsync_out,
	output logic vsync_out,
	output logic blank_out,
	output track_pkg::readout_t readout
);

	// switch 1 and 0 select the mode, switch 0 alone enables com readout
	video_pkg::overlay_mode_e mode;
	logic track_en;

	wire track_pkg::buttons_t buttons_db;
	track_pkg::pos_t cursor;
	track_pkg::pos_t com_latched;
	video_pkg::raster_t raster_del;

	assign mode = video_pkg::overlay_mode_e'(switches);
	assign track_en = switches[0];

	//////////////////////////////
	// buttons and cursor
	//////////////////////////////

	// one debouncer per direction
	for (genvar i = 0; i < 4; i++) begin : g_db
		debounce u_debounce (
			.clk(clk),
			.rst(rst),
			.raw(buttons[i]),
			.clean(buttons_db[i])
		);
	end

	cursor_mover u_cursor_mover (
		.clk(clk),
		.rst(rst),
		.buttons(buttons_db),
		.cursor(cursor)
	);

	//////////////////////////////
	// video path
	//////////////////////////////

	// raster delayed by the hsv latency
	sync_delay u_sync_delay (
		.clk(clk),
		.rst(rst),
		.raster(raster),
		.raster_del(raster_del)
	);

	overlay_mixer u_overlay_mixer (
		.clk(clk),
		.rst(rst),
		.mode(mode),
		.raster(raster),
		.raster_del(raster_del),
		.pixel_in(pixel_in),
		.hsv_in(hsv_in),
		.com_pos(com_pos),
		.light_pos(light_pos),
		.cursor(cursor),
		.com_ready(com_ready),
		.pixel_out(pixel_out),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out),
		.blank_out(blank_out),
		.com_latched(com_latched)
	);

	readout_latch u_readout_latch (
		.clk(clk),
		.rst(rst),
		.track_en(track_en),
		.raster_del(raster_del),
		.hsv_in(hsv_in),
		.com_latched(com_latched),
		.cursor(cursor),
		.readout(readout)
	);

endmodule

`default_nettype wire

// ==== verilog/video_pkg.sv ====
//////////////////////////////
// video types
// raster timing, pixel, hsv and overlay mode
//////////////////////////////

`default_nettype none

package video_pkg;

	// one pixel, 6 bits per channel
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb666_t;

	// hsv triple as delivered by the converter
	typedef struct packed {
		logic [7:0] h;
		logic [7:0] s;
		logic [7:0] v;
	} hsv_t;

	// xga raster position and syncs, 24 bits
	typedef struct packed {
		logic [10:0] hcount;
		logic [9:0] vcount;
		logic hsync;
		logic vsync;
		logic blank;
	} raster_t;

	// the two switches, bit 1 then bit 0
	typedef enum logic [1:0] {
		MODE_VIDEO = 2'd0,
		MODE_TRACK = 2'd1,
		MODE_CURSOR = 2'd2,
		MODE_HSV = 2'd3
	} overlay_mode_e;

endpackage

`default_nettype wire
